//--- Makefile
TOP = proc_host_tb

.PHONY: all compile run clean

all: run

compile:
	verilator --binary -j 0 --top-module $(TOP) -f proc_host.f

run: compile
	./obj_dir/V$(TOP) | tee sim.log
	grep -q '^>>> PASS$$' sim.log

clean:
	rm -rf obj_dir sim.log

//--- logic/alu_execute.sv
// ##################################################
// Execute stage, all operations complete in one cycle
// ##################################################
`include "proc_host_cfg.svh"

module alu_execute
    import proc_isa_pkg::*;
(
    input  logic                clk,
    input  logic                rst,
    input  logic                dec_valid,
    input  opcode_t             dec_op,
    input  reg_idx_t            dec_rd,
    input  logic [`PH_XLEN-1:0] dec_a,
    input  logic [`PH_XLEN-1:0] dec_b,
    input  mix_sel_t            dec_sel,
    input  logic [7:0]          dec_e,
    output logic                ex_valid,
    output reg_idx_t            ex_rd,
    output logic [`PH_XLEN-1:0] ex_value
);
    logic [15:0]         mix_y;
    logic [`PH_XLEN-1:0] alu_y;

    // Low half-words of both operands feed the mixer
    operand_mixer i_mixer (
        .a   (dec_a[7:0]),
        .b   (dec_a[15:8]),
        .c   (dec_b[7:0]),
        .d   (dec_b[15:8]),
        .e   (dec_e),
        .sel (dec_sel),
        .y   (mix_y)
    );

    always_comb begin
        case (dec_op)
            OP_ADD:  alu_y = dec_a + dec_b;
            OP_SUB:  alu_y = dec_a - dec_b;
            OP_AND:  alu_y = dec_a & dec_b;
            OP_OR:   alu_y = dec_a | dec_b;
            OP_XOR:  alu_y = dec_a ^ dec_b;
            OP_SHL:  alu_y = dec_a << dec_b[4:0];
            OP_SHR:  alu_y = dec_a >> dec_b[4:0];  // Logical
            OP_MIX:  alu_y = {{(`PH_XLEN - 16){1'b0}}, mix_y};
            default: alu_y = '0;
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            ex_valid <= 1'b0;
        end else begin
            ex_valid <= dec_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (dec_valid) begin
            ex_rd    <= dec_rd;
            ex_value <= alu_y;
        end
    end

endmodule

//--- logic/host_apb_regs.sv
// ##################################################
// APB slave. Register accesses wait while the core is busy,
// INSTR writes never wait. Misaligned offsets count as unmapped
// ##################################################
`include "proc_host_cfg.svh"

module host_apb_regs
    import proc_isa_pkg::*;
    import host_bus_pkg::*;
(
    input  logic                   clk,
    input  logic                   rst,
    input  logic [`PH_PADDR_W-1:0] paddr,
    input  logic                   psel,
    input  logic                   penable,
    input  logic                   pwrite,
    input  logic [`PH_XLEN-1:0]    pwdata,
    output logic [`PH_XLEN-1:0]    prdata,
    output logic                   pready,
    output logic                   pslverr,
    input  logic                   busy,
    input  logic [`PH_XLEN-1:0]    result,
    input  logic [7:0]             status_cnt,
    input  logic [`PH_XLEN-1:0]    host_rdata,
    output logic                   instr_valid,
    output logic [`PH_XLEN-1:0]    instr,
    output logic                   host_we,
    output reg_idx_t               host_idx,
    output logic [`PH_XLEN-1:0]    host_wdata
);
    logic    setup;
    logic    access;
    logic    hit_reg;
    logic    hit_instr;
    logic    hit_result;
    logic    hit_status;
    logic    post;
    status_t status_w;

    assign setup  = psel && !penable;
    assign access = psel && penable;

    assign hit_reg    = (paddr <= REGS_LAST) && (paddr[1:0] == 2'b00);
    assign hit_instr  = (paddr == INSTR_OFS);
    assign hit_result = (paddr == RESULT_OFS);
    assign hit_status = (paddr == STATUS_OFS);

    // Latched in the setup phase, so decode sees it during the access cycle
    assign post = setup && pwrite && hit_instr;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            instr_valid <= 1'b0;
        end else begin
            instr_valid <= post;  // Single cycle, APB needs two per transfer
        end
    end

    always_ff @(posedge clk) begin
        if (post) begin
            instr <= pwdata;
        end
    end

    // Register file port is shared with writeback, so hold the host off
    assign pready = !(access && hit_reg && busy);

    assign host_we    = access && pwrite && hit_reg && !busy;
    assign host_idx   = reg_idx_t'((paddr - REGS_BASE) >> 2);
    assign host_wdata = pwdata;

    assign pslverr = access &&
                     ((pwrite && (hit_result || hit_status)) ||
                      !(hit_reg || hit_instr || hit_result || hit_status));

    always_comb begin
        status_w         = '0;
        status_w.busy    = busy;
        status_w.retired = status_cnt;
        prdata           = '0;  // INSTR and unmapped read as zero
        if (hit_reg) begin
            prdata = host_rdata;
        end else if (hit_result) begin
            prdata = result;
        end else if (hit_status) begin
            prdata = status_w;
        end
    end

endmodule

//--- logic/host_bus_pkg.sv
// ##################################################
// APB register map of the host port, word aligned offsets only
// ##################################################
`include "proc_host_cfg.svh"

package host_bus_pkg;

    localparam logic [`PH_PADDR_W-1:0] REGS_BASE  = 'h00;
    localparam logic [`PH_PADDR_W-1:0] REGS_LAST  = 'h7C;  // One word per register
    localparam logic [`PH_PADDR_W-1:0] INSTR_OFS  = 'h80;  // Write only
    localparam logic [`PH_PADDR_W-1:0] RESULT_OFS = 'h84;  // Read only
    localparam logic [`PH_PADDR_W-1:0] STATUS_OFS = 'h88;  // Read only

    typedef struct packed {
        logic [15:0] rsvd_hi;
        logic [7:0]  retired;  // Wraps at 256
        logic [6:0]  rsvd_lo;
        logic        busy;
    } status_t;

endpackage

//--- logic/instr_decode.sv
// ##################################################
// Decode stage. Forwards only from the writeback-bound result,
// which relies on instructions arriving at most every other cycle
// ##################################################
`include "proc_host_cfg.svh"

module instr_decode
    import proc_isa_pkg::*;
(
    input  logic                clk,
    input  logic                rst,
    input  logic                instr_valid,
    input  logic [`PH_XLEN-1:0] instr,
    output reg_idx_t            rs1_idx,
    output reg_idx_t            rs2_idx,
    input  logic [`PH_XLEN-1:0] rs1_val,
    input  logic [`PH_XLEN-1:0] rs2_val,
    input  logic                ex_valid,
    input  reg_idx_t            ex_rd,
    input  logic [`PH_XLEN-1:0] ex_value,
    output logic                dec_valid,
    output opcode_t             dec_op,
    output reg_idx_t            dec_rd,
    output logic [`PH_XLEN-1:0] dec_a,
    output logic [`PH_XLEN-1:0] dec_b,
    output mix_sel_t            dec_sel,
    output logic [7:0]          dec_e
);
    instr_t              fields;
    logic [`PH_XLEN-1:0] op_a;
    logic [`PH_XLEN-1:0] op_b;

    assign fields  = instr;
    assign rs1_idx = fields.rs1;
    assign rs2_idx = fields.rs2;

    // APB pacing keeps execute empty whenever a new instruction is here,
    // so the producer of a dependent operand sits in the ex registers
    assign op_a = (ex_valid && ex_rd == fields.rs1) ? ex_value : rs1_val;
    assign op_b = (ex_valid && ex_rd == fields.rs2) ? ex_value : rs2_val;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            dec_valid <= 1'b0;
        end else begin
            dec_valid <= instr_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (instr_valid) begin
            dec_op  <= fields.op;
            dec_rd  <= fields.rd;
            dec_a   <= op_a;
            dec_b   <= op_b;
            dec_sel <= fields.mix_sel;
            dec_e   <= fields.mix_e;
        end
    end

endmodule

//--- logic/operand_mixer.sv
// ##################################################
// Combinational byte mixer, five bytes in and 16 bits out
// ##################################################
module operand_mixer
    import proc_isa_pkg::*;
(
    input  logic [7:0]  a,
    input  logic [7:0]  b,
    input  logic [7:0]  c,
    input  logic [7:0]  d,
    input  logic [7:0]  e,
    input  mix_sel_t    sel,
    output logic [15:0] y
);
    logic [31:0] rot_bc;

    // Doubled word so the upper half holds the rotated value
    assign rot_bc = {b, c, b, c} << e[3:0];

    always_comb begin
        case (sel)
            MIX_MUL_AB:   y = {8'h00, a} * {8'h00, b};
            MIX_CAT_AB:   y = {a, b};
            MIX_XOR_CD_E: y = {c ^ d, e};
            MIX_SUM_ABC:  y = 16'(a) + 16'(b) + 16'(c);
            MIX_AND_OR:   y = {a & e, d | e};
            MIX_ROT_BC:   y = rot_bc[31:16];
            MIX_SWAP_DE:  y = {e, d} & 16'hF0F0;
            MIX_MUL_AE_X: y = ({8'h00, a} * {8'h00, e}) ^ 16'h00FF;
            default:      y = '0;
        endcase
    end

endmodule

//--- logic/proc_host.sv
// ##################################################
// Three stage core behind an APB slave. Results land 3 cycles
// after the INSTR access cycle
// ##################################################
`include "proc_host_cfg.svh"

module proc_host
    import proc_isa_pkg::*;
(
    input  logic                   clk,
    input  logic                   rst,
    input  logic [`PH_PADDR_W-1:0] paddr,
    input  logic                   psel,
    input  logic                   penable,
    input  logic                   pwrite,
    input  logic [`PH_XLEN-1:0]    pwdata,
    output logic [`PH_XLEN-1:0]    prdata,
    output logic                   pready,
    output logic                   pslverr
);
    logic                busy;
    logic                instr_valid;
    logic [`PH_XLEN-1:0] instr;
    logic                host_we;
    reg_idx_t            host_idx;
    logic [`PH_XLEN-1:0] host_wdata;
    logic [`PH_XLEN-1:0] host_rdata;
    logic [`PH_XLEN-1:0] result;
    logic [7:0]          status_cnt;
    reg_idx_t            rs1_idx;
    reg_idx_t            rs2_idx;
    logic [`PH_XLEN-1:0] rs1_val;
    logic [`PH_XLEN-1:0] rs2_val;
    logic                dec_valid;
    opcode_t             dec_op;
    reg_idx_t            dec_rd;
    logic [`PH_XLEN-1:0] dec_a;
    logic [`PH_XLEN-1:0] dec_b;
    mix_sel_t            dec_sel;
    logic [7:0]          dec_e;
    logic                ex_valid;
    reg_idx_t            ex_rd;
    logic [`PH_XLEN-1:0] ex_value;

    assign busy = instr_valid | dec_valid | ex_valid;  // Any stage occupied

    host_apb_regs i_apb (
        .clk, .rst, .paddr, .psel, .penable, .pwrite, .pwdata,
        .prdata, .pready, .pslverr,
        .busy, .result, .status_cnt, .host_rdata,
        .instr_valid, .instr, .host_we, .host_idx, .host_wdata
    );

    instr_decode i_decode (
        .clk, .rst, .instr_valid, .instr,
        .rs1_idx, .rs2_idx, .rs1_val, .rs2_val,
        .ex_valid, .ex_rd, .ex_value,
        .dec_valid, .dec_op, .dec_rd, .dec_a, .dec_b, .dec_sel, .dec_e
    );

    alu_execute i_execute (
        .clk, .rst,
        .dec_valid, .dec_op, .dec_rd, .dec_a, .dec_b, .dec_sel, .dec_e,
        .ex_valid, .ex_rd, .ex_value
    );

    result_writeback i_writeback (
        .clk, .rst, .ex_valid, .ex_rd, .ex_value,
        .rs1_idx, .rs2_idx, .rs1_val, .rs2_val,
        .host_we, .host_idx, .host_wdata,
        .host_rdata, .result, .status_cnt
    );

endmodule

//--- logic/proc_host_cfg.svh
// ##################################################
// Core sizes and reset pattern. PH_XLEN must stay 32 because
// the status word and the instruction layout are fixed at 32 bits
// ##################################################
`ifndef PROC_HOST_CFG_SVH
`define PROC_HOST_CFG_SVH

`define PH_NREGS    32            // General registers, index is 5 bits
`define PH_XLEN     32            // Data path width
`define PH_REG_INIT 32'h76543210  // Register i resets to this plus i
`define PH_PADDR_W  8             // APB address bits

`endif

//--- logic/proc_isa_pkg.sv
// ##################################################
// Instruction set types. Bits 20:18 of an instruction are ignored
// ##################################################
package proc_isa_pkg;

    typedef enum logic [2:0] {
        OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR, OP_SHL, OP_SHR, OP_MIX
    } opcode_t;

    typedef logic [4:0] reg_idx_t;

    // Selects one of the eight byte combiners in the mixer
    typedef enum logic [2:0] {
        MIX_MUL_AB, MIX_CAT_AB, MIX_XOR_CD_E, MIX_SUM_ABC,
        MIX_AND_OR, MIX_ROT_BC, MIX_SWAP_DE, MIX_MUL_AE_X
    } mix_sel_t;

    typedef struct packed {
        logic [7:0] mix_e;    // 31:24
        mix_sel_t   mix_sel;  // 23:21
        logic [2:0] rsvd;     // 20:18
        reg_idx_t   rs2;      // 17:13
        reg_idx_t   rs1;      // 12:8
        reg_idx_t   rd;       // 7:3
        opcode_t    op;       // 2:0
    } instr_t;

endpackage

//--- logic/result_writeback.sv
// ##################################################
// Register file and result. Pipeline write wins over a host write
// ##################################################
`include "proc_host_cfg.svh"

module result_writeback
    import proc_isa_pkg::*;
(
    input  logic                clk,
    input  logic                rst,
    input  logic                ex_valid,
    input  reg_idx_t            ex_rd,
    input  logic [`PH_XLEN-1:0] ex_value,
    input  reg_idx_t            rs1_idx,
    input  reg_idx_t            rs2_idx,
    output logic [`PH_XLEN-1:0] rs1_val,
    output logic [`PH_XLEN-1:0] rs2_val,
    input  logic                host_we,
    input  reg_idx_t            host_idx,
    input  logic [`PH_XLEN-1:0] host_wdata,
    output logic [`PH_XLEN-1:0] host_rdata,
    output logic [`PH_XLEN-1:0] result,
    output logic [7:0]          status_cnt
);
    logic [`PH_XLEN-1:0] regs [`PH_NREGS];

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < `PH_NREGS; i++) begin
                regs[i] <= `PH_XLEN'(`PH_REG_INIT + i);
            end
            result     <= '0;
            status_cnt <= '0;
        end else if (ex_valid) begin
            regs[ex_rd] <= ex_value;  // r0 is an ordinary register
            result      <= ex_value;
            status_cnt  <= status_cnt + 8'd1;
        end else if (host_we) begin
            regs[host_idx] <= host_wdata;
        end
    end

    assign rs1_val    = regs[rs1_idx];
    assign rs2_val    = regs[rs2_idx];
    assign host_rdata = regs[host_idx];

endmodule

//--- proc_host.f
+incdir+logic
logic/proc_isa_pkg.sv
logic/host_bus_pkg.sv
logic/operand_mixer.sv
logic/host_apb_regs.sv
logic/instr_decode.sv
logic/alu_execute.sv
logic/result_writeback.sv
logic/proc_host.sv
test/proc_host_tb.sv

//--- test/proc_host_stimulus.txt
# name cmd offset data expected, all numbers in hex
# W expects pslverr in the last column, R expects read data, P idles data cycles
rst_r0        R 00 00000000 76543210
rst_r5        R 14 00000000 76543215
rst_r31       R 7C 00000000 7654322F
rst_result    R 84 00000000 00000000
rst_status    R 88 00000000 00000000
set_r1        W 04 00001234 00000000
set_r2        W 08 00000F0F 00000000
set_r3        W 0C 00000004 00000000
alu_add       W 80 00004150 00000000
alu_sub       W 80 00002259 00000000
alu_and       W 80 00004162 00000000
alu_or        W 80 0000416B 00000000
alu_xor       W 80 00004174 00000000
alu_shl       W 80 0000617D 00000000
alu_shr       W 80 00006186 00000000
alu_drain     P 00 00000005 00000000
alu_add_r10   R 28 00000000 00002143
alu_sub_r11   R 2C 00000000 FFFFFCDB
alu_and_r12   R 30 00000000 00000204
alu_or_r13    R 34 00000000 00001F3F
alu_xor_r14   R 38 00000000 00001D3B
alu_shl_r15   R 3C 00000000 00012340
alu_shr_r16   R 40 00000000 00000123
alu_result    R 84 00000000 00000123
alu_status    R 88 00000000 00000700
set_r4        W 10 0000B7A5 00000000
set_r5        W 14 00003C5D 00000000
mix_sel0      W 80 9300A48F 00000000
mix_sel1      W 80 9320A497 00000000
mix_sel2      W 80 9340A49F 00000000
mix_sel3      W 80 9360A4A7 00000000
mix_sel4      W 80 9380A4AF 00000000
mix_sel5      W 80 93A0A4B7 00000000
mix_sel6      W 80 93C0A4BF 00000000
mix_sel7      W 80 93E0A4C7 00000000
mix_drain     P 00 00000005 00000000
mix_r17       R 44 00000000 000075F3
mix_r18       R 48 00000000 0000A5B7
mix_r19       R 4C 00000000 00006193
mix_r20       R 50 00000000 000001B9
mix_r21       R 54 00000000 000081BF
mix_r22       R 58 00000000 0000BAED
mix_r23       R 5C 00000000 00009030
mix_r24       R 60 00000000 00005E40
set_r6        W 18 00000010 00000000
set_r7        W 1C 00000003 00000000
chain_add     W 80 0000E640 00000000
chain_shl     W 80 0000E84D 00000000
chain_sub     W 80 0000C9C9 00000000
chain_r25     R 64 00000000 00000088
chain_r8      R 20 00000000 00000013
chain_r9      R 24 00000000 00000098
chain_result  R 84 00000000 00000088
chain_status  R 88 00000000 00001200
err_result    W 84 00000000 00000001
err_unmapped  W FC 00000000 00000001

//--- test/proc_host_tb.sv
// ##################################################
// Run from the project root, reads test/proc_host_stimulus.txt
// ##################################################
`include "proc_host_cfg.svh"

module proc_host_tb;
    timeunit 1ns;
    timeprecision 100ps;

    logic                   clk;
    logic                   rst;
    logic [`PH_PADDR_W-1:0] paddr;
    logic                   psel;
    logic                   penable;
    logic                   pwrite;
    logic [`PH_XLEN-1:0]    pwdata;
    logic [`PH_XLEN-1:0]    prdata;
    logic                   pready;
    logic                   pslverr;

    int                     errors;
    int                     checks;
    int                     fd;
    int                     code;
    logic [8*24-1:0]        name;
    logic [7:0]             cmd;
    logic [8*120-1:0]       line;
    logic [`PH_PADDR_W-1:0] ofs;
    logic [`PH_XLEN-1:0]    data;
    logic [`PH_XLEN-1:0]    expv;
    logic [`PH_XLEN-1:0]    rdata;
    logic                   err;

    proc_host i_dut (
        .clk, .rst, .paddr, .psel, .penable, .pwrite, .pwdata,
        .prdata, .pready, .pslverr
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // Setup then access; returns still in the access phase so transfers chain
    task automatic bus_access(input logic wr, input logic [`PH_PADDR_W-1:0] addr,
                              input logic [`PH_XLEN-1:0] wdata,
                              output logic [`PH_XLEN-1:0] rd_val, output logic slv_err);
        int waits;
        waits = 0;
        @(posedge clk);
        #1;
        paddr   = addr;
        pwrite  = wr;
        pwdata  = wdata;
        psel    = 1'b1;
        penable = 1'b0;
        @(posedge clk);
        #1;
        penable = 1'b1;
        @(negedge clk);  // Outputs settled mid cycle
        while (!pready && waits < 50) begin
            @(negedge clk);
            waits++;
        end
        if (!pready) begin
            $display("error: pready stayed low for 50 cycles at offset %h", addr);
            errors++;
        end
        rd_val  = prdata;
        slv_err = pslverr;
    endtask

    task automatic apb_write(input logic [`PH_PADDR_W-1:0] addr,
                             input logic [`PH_XLEN-1:0] wdata, output logic slv_err);
        logic [`PH_XLEN-1:0] unused;
        bus_access(1'b1, addr, wdata, unused, slv_err);
    endtask

    task automatic apb_read(input logic [`PH_PADDR_W-1:0] addr,
                            output logic [`PH_XLEN-1:0] rd_val);
        logic unused;
        bus_access(1'b0, addr, '0, rd_val, unused);
    endtask

    task automatic bus_idle(input logic [`PH_XLEN-1:0] cycles);
        int n;
        n = (cycles > 1000) ? 1000 : int'(cycles);
        @(posedge clk);
        #1;
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
        for (int i = 1; i < n; i++) begin
            @(posedge clk);
        end
    endtask

    initial begin
        errors  = 0;
        checks  = 0;
        rst     = 1'b1;
        paddr   = '0;
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
        pwdata  = '0;
        repeat (5) @(posedge clk);
        #1;
        rst = 1'b0;

        fd = $fopen("test/proc_host_stimulus.txt", "r");
        if (fd == 0) begin
            $display("error: cannot open the stimulus file");
            errors++;
        end else begin
            code = $fscanf(fd, "%s", name);
            while (code == 1) begin
                if (name[7:0] == "#") begin
                    code = $fgets(line, fd);  // Column notes
                end else begin
                    code = $fscanf(fd, "%s %h %h %h", cmd, ofs, data, expv);
                    if (code != 4) begin
                        $display("error: stimulus line %0s is incomplete", name);
                        errors++;
                    end else if (cmd == "W") begin
                        apb_write(ofs, data, err);
                        checks++;
                        if (err !== expv[0]) begin
                            $display("mismatch %0s: expected pslverr %0d, actual %0d",
                                     name, expv[0], err);
                            errors++;
                        end
                    end else if (cmd == "R") begin
                        apb_read(ofs, rdata);
                        checks++;
                        if (rdata !== expv) begin
                            $display("mismatch %0s: expected %h, actual %h",
                                     name, expv, rdata);
                            errors++;
                        end
                    end else if (cmd == "P") begin
                        bus_idle(data);
                    end else begin
                        $display("error: unknown command in stimulus line %0s", name);
                        errors++;
                    end
                end
                code = $fscanf(fd, "%s", name);
            end
            $fclose(fd);
        end

        bus_idle(2);
        $display("%0d checks, %0d errors", checks, errors);
        if (errors == 0 && checks > 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule
